//--- cache_control/cache_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module cache_control (
	input logic clk,
	input logic rst,

	// Arbiter handshake
	input logic mem_read,
	input logic mem_write,
	output logic mem_resp,

	// Memory handshake
	output logic pmem_read,
	output logic pmem_write,
	input logic pmem_resp,

	// Status from datapath
	input logic hit,
	input logic victim_dirty,

	// Strobes to datapath
	output logic tag_load,
	output logic valid_load,
	output logic dirty_load,
	output logic dirty_in,
	output logic data_write,
	output logic fill,
	output logic lru_load,
	output logic writeback_sel
);

	typedef enum logic [1:0] {
		IDLE,
		CHECK,
		WRITEBACK,
		ALLOCATE
	} state_t;

	state_t state;
	state_t next_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		tag_load = 1'b0;
		valid_load = 1'b0;
		dirty_load = 1'b0;
		dirty_in = 1'b0;
		data_write = 1'b0;
		fill = 1'b0;
		lru_load = 1'b0;
		writeback_sel = 1'b0;

		case (state)
			IDLE: begin
				if (mem_read || mem_write) begin
					next_state = CHECK;
				end
			end

			CHECK: begin
				if (hit) begin
					mem_resp = 1'b1;
					lru_load = 1'b1;
					// Hit write marks the line dirty
					if (mem_write) begin
						data_write = 1'b1;
						dirty_load = 1'b1;
						dirty_in = 1'b1;
					end
					next_state = IDLE;
				end else if (victim_dirty) begin
					next_state = WRITEBACK;
				end else begin
					next_state = ALLOCATE;
				end
			end

			WRITEBACK: begin
				pmem_write = 1'b1;
				writeback_sel = 1'b1;
				if (pmem_resp) begin
					next_state = ALLOCATE;
				end
			end

			ALLOCATE: begin
				pmem_read = 1'b1;
				// Line arrives in the response cycle
				if (pmem_resp) begin
					fill = 1'b1;
					tag_load = 1'b1;
					valid_load = 1'b1;
					dirty_load = 1'b1;
					next_state = CHECK;
				end
			end

			default: next_state = IDLE;
		endcase
	end

endmodule

`default_nettype wire

//--- cache_datapath/cache_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module cache_datapath (
	input logic clk,
	input logic rst,

	// Arbiter side
	input logic [31:0] mem_address,
	input cache_pkg::line_t mem_wdata,
	output cache_pkg::line_t mem_rdata,

	// Memory side
	input cache_pkg::line_t pmem_rdata,
	output cache_pkg::line_t pmem_wdata,
	output logic [31:0] pmem_address,

	// Strobes from control
	input logic tag_load,
	input logic valid_load,
	input logic dirty_load,
	input logic dirty_in,
	input logic data_write,
	input logic fill,
	input logic lru_load,
	input logic writeback_sel,

	// Status to control
	output logic hit,
	output logic victim_dirty
);

	cache_pkg::tag_t addr_tag;
	cache_pkg::index_t index;

	// Per-way outputs of the set arrays
	cache_pkg::line_t way_line [`CACHE_WAYS];
	cache_pkg::tag_t way_tag [`CACHE_WAYS];
	logic [`CACHE_WAYS-1:0] way_valid;
	logic [`CACHE_WAYS-1:0] way_dirty;

	cache_pkg::way_sel_t hit_way;
	cache_pkg::way_sel_t victim;
	cache_pkg::way_sel_t line_load;
	cache_pkg::way_sel_t dirty_sel;

	cache_pkg::plru_t plru_state;
	cache_pkg::plru_t plru_next;
	logic lru_write;

	cache_pkg::line_t line_in;
	cache_pkg::tag_t victim_tag;

	assign addr_tag = mem_address[`CACHE_OFFSET_BITS + `CACHE_INDEX_BITS +: `CACHE_TAG_BITS];
	assign index = mem_address[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];

	// Fills come from memory, hit writes from the arbiter
	assign line_in = fill ? pmem_rdata : mem_wdata;

	genvar w;
	generate
		for (w = 0; w < `CACHE_WAYS; w++) begin : g_way
			assign hit_way[w] = way_valid[w] && (way_tag[w] == addr_tag);
			assign line_load[w] = (data_write && hit_way[w]) || (fill && victim[w]);
			// Dirty bit goes to the victim during a fill, else to the hit way
			assign dirty_sel[w] = fill ? victim[w] : hit_way[w];

			set_array #(.payload_t(cache_pkg::line_t)) u_line (
				.clk     (clk),
				.rst     (rst),
				.load    (line_load[w]),
				.index   (index),
				.datain  (line_in),
				.dataout (way_line[w])
			);

			set_array #(.payload_t(cache_pkg::tag_t)) u_tag (
				.clk     (clk),
				.rst     (rst),
				.load    (tag_load && victim[w]),
				.index   (index),
				.datain  (addr_tag),
				.dataout (way_tag[w])
			);

			set_array u_valid (
				.clk     (clk),
				.rst     (rst),
				.load    (valid_load && victim[w]),
				.index   (index),
				.datain  (1'b1),
				.dataout (way_valid[w])
			);

			set_array u_dirty (
				.clk     (clk),
				.rst     (rst),
				.load    (dirty_load && dirty_sel[w]),
				.index   (index),
				.datain  (dirty_in),
				.dataout (way_dirty[w])
			);
		end
	endgenerate

	assign hit = |hit_way;

	// Tree only moves on an actual hit
	assign lru_write = lru_load && hit;

	set_array #(.payload_t(cache_pkg::plru_t)) u_plru_state (
		.clk     (clk),
		.rst     (rst),
		.load    (lru_write),
		.index   (index),
		.datain  (plru_next),
		.dataout (plru_state)
	);

	plru_tree u_plru (
		.state      (plru_state),
		.hit_way    (hit_way),
		.next_state (plru_next),
		.victim     (victim)
	);

	// One-hot selects, so OR the chosen ways together
	always_comb begin
		mem_rdata = '0;
		pmem_wdata = '0;
		victim_tag = '0;
		victim_dirty = 1'b0;
		for (int i = 0; i < `CACHE_WAYS; i++) begin
			if (hit_way[i]) begin
				mem_rdata = mem_rdata | way_line[i];
			end
			if (victim[i]) begin
				pmem_wdata = pmem_wdata | way_line[i];
				victim_tag = victim_tag | way_tag[i];
				victim_dirty = victim_dirty | way_dirty[i];
			end
		end
	end

	// Line aligned in both cases
	assign pmem_address = writeback_sel ?
		{victim_tag, index, {`CACHE_OFFSET_BITS{1'b0}}} :
		{addr_tag, index, {`CACHE_OFFSET_BITS{1'b0}}};

endmodule

`default_nettype wire

//--- common/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Address split for 32-bit byte addresses
`define CACHE_OFFSET_BITS 5
`define CACHE_INDEX_BITS 3
`define CACHE_TAG_BITS 24

// Geometry
`define CACHE_WAYS 4
`define CACHE_SETS 8

// One line is 32 bytes
`define CACHE_LINE_BITS 256

`endif

//--- common/cache_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

	// Whole cache line, eight 32-bit words
	typedef logic [`CACHE_LINE_BITS-1:0] line_t;

	// Stored tag and set index
	typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
	typedef logic [`CACHE_INDEX_BITS-1:0] index_t;

	// Tree pLRU state for four ways
	// bit 2 picks the pair, bit 1 within ways 0/1, bit 0 within ways 2/3
	typedef logic [`CACHE_WAYS-2:0] plru_t;

	// One-hot way select
	typedef logic [`CACHE_WAYS-1:0] way_sel_t;

endpackage

`default_nettype wire

//--- logic/l2_cache.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module l2_cache (
	input logic clk,
	input logic rst,

	// Arbiter side
	input logic [31:0] mem_address,
	input logic mem_read,
	input logic mem_write,
	input cache_pkg::line_t mem_wdata,
	output cache_pkg::line_t mem_rdata,
	output logic mem_resp,

	// Cacheline adaptor side
	output logic [31:0] pmem_address,
	output logic pmem_read,
	output logic pmem_write,
	output cache_pkg::line_t pmem_wdata,
	input cache_pkg::line_t pmem_rdata,
	input logic pmem_resp
);

	logic tag_load;
	logic valid_load;
	logic dirty_load;
	logic dirty_in;
	logic data_write;
	logic fill;
	logic lru_load;
	logic writeback_sel;
	logic hit;
	logic victim_dirty;

	cache_control u_control (
		.clk           (clk),
		.rst           (rst),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.mem_resp      (mem_resp),
		.pmem_read     (pmem_read),
		.pmem_write    (pmem_write),
		.pmem_resp     (pmem_resp),
		.hit           (hit),
		.victim_dirty  (victim_dirty),
		.tag_load      (tag_load),
		.valid_load    (valid_load),
		.dirty_load    (dirty_load),
		.dirty_in      (dirty_in),
		.data_write    (data_write),
		.fill          (fill),
		.lru_load      (lru_load),
		.writeback_sel (writeback_sel)
	);

	cache_datapath u_datapath (
		.clk           (clk),
		.rst           (rst),
		.mem_address   (mem_address),
		.mem_wdata     (mem_wdata),
		.mem_rdata     (mem_rdata),
		.pmem_rdata    (pmem_rdata),
		.pmem_wdata    (pmem_wdata),
		.pmem_address  (pmem_address),
		.tag_load      (tag_load),
		.valid_load    (valid_load),
		.dirty_load    (dirty_load),
		.dirty_in      (dirty_in),
		.data_write    (data_write),
		.fill          (fill),
		.lru_load      (lru_load),
		.writeback_sel (writeback_sel),
		.hit           (hit),
		.victim_dirty  (victim_dirty)
	);

endmodule

`default_nettype wire

//--- logic/plru_tree.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module plru_tree (
	input cache_pkg::plru_t state,
	input cache_pkg::way_sel_t hit_way,
	output cache_pkg::plru_t next_state,
	output cache_pkg::way_sel_t victim
);

	// Point the tree away from the way just used
	always_comb begin
		next_state = state;
		case (hit_way)
			4'b0001: begin
				next_state[1] = 1'b1;
				next_state[2] = 1'b1;
			end
			4'b0010: begin
				next_state[1] = 1'b0;
				next_state[2] = 1'b1;
			end
			4'b0100: begin
				next_state[0] = 1'b1;
				next_state[2] = 1'b0;
			end
			4'b1000: begin
				next_state[0] = 1'b0;
				next_state[2] = 1'b0;
			end
			default: next_state = state;
		endcase
	end

	// Follow the tree down to the victim
	always_comb begin
		victim = '0;
		if (!state[2]) begin
			victim[state[1] ? 1 : 0] = 1'b1;
		end else begin
			victim[state[0] ? 3 : 2] = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/set_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module set_array #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst,
	input logic load,
	input cache_pkg::index_t index,
	input payload_t datain,
	output payload_t dataout
);

	// One entry per set
	payload_t entries [`CACHE_SETS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CACHE_SETS; i++) begin
				entries[i] <= '0;
			end
		end else if (load) begin
			entries[index] <= datain;
		end
	end

	// Asynchronous read
	assign dataout = entries[index];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module l2_cache_tb -o l2_cache_sim

# The simulator exits non-zero on a failed check, so keep its output for the search
output="$(./obj_dir/l2_cache_sim 2>&1)" || true
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
else
	exit 1
fi

//--- sources.f
+incdir+common
common/cache_pkg.sv
logic/set_array.sv
logic/plru_tree.sv
cache_datapath/cache_datapath.sv
cache_control/cache_control.sv
logic/l2_cache.sv
test/clock_gen.sv
test/pmem_model.sv
test/l2_cache_tb.sv

//--- test/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
	output logic clk,
	output logic rst
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// Reset seen on three rising edges, released just after the third
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#2 rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- test/l2_cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module l2_cache_tb;

	logic clk;
	logic rst;
	logic [31:0] mem_address;
	logic mem_read;
	logic mem_write;
	cache_pkg::line_t mem_wdata;
	cache_pkg::line_t mem_rdata;
	logic mem_resp;
	logic [31:0] pmem_address;
	logic pmem_read;
	logic pmem_write;
	cache_pkg::line_t pmem_wdata;
	cache_pkg::line_t pmem_rdata;
	logic pmem_resp;
	logic stall;
	int read_count;
	int write_count;
	logic [31:0] last_read_addr;
	logic [31:0] last_write_addr;
	cache_pkg::line_t last_write_data;
	logic hold_error;

	// Reference copy of the cache contents
	cache_pkg::line_t ref_lines [`CACHE_SETS][`CACHE_WAYS];
	cache_pkg::tag_t ref_tags [`CACHE_SETS][`CACHE_WAYS];
	logic ref_valid [`CACHE_SETS][`CACHE_WAYS];
	logic ref_dirty [`CACHE_SETS][`CACHE_WAYS];
	cache_pkg::plru_t ref_plru [`CACHE_SETS];
	cache_pkg::line_t ref_mem [logic [31:0]];

	clock_gen clocks (
		.clk (clk),
		.rst (rst)
	);

	l2_cache uut (
		.clk          (clk),
		.rst          (rst),
		.mem_address  (mem_address),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_wdata    (mem_wdata),
		.mem_rdata    (mem_rdata),
		.mem_resp     (mem_resp),
		.pmem_address (pmem_address),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_wdata   (pmem_wdata),
		.pmem_rdata   (pmem_rdata),
		.pmem_resp    (pmem_resp)
	);

	pmem_model memory (
		.clk             (clk),
		.rst             (rst),
		.pmem_address    (pmem_address),
		.pmem_read       (pmem_read),
		.pmem_write      (pmem_write),
		.pmem_wdata      (pmem_wdata),
		.pmem_rdata      (pmem_rdata),
		.pmem_resp       (pmem_resp),
		.stall           (stall),
		.read_count      (read_count),
		.write_count     (write_count),
		.last_read_addr  (last_read_addr),
		.last_write_addr (last_write_addr),
		.last_write_data (last_write_data),
		.hold_error      (hold_error)
	);

	task automatic stop_with_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_line(input string name, input cache_pkg::line_t exp,
		input cache_pkg::line_t act);
		if (exp !== act) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
			stop_with_failure();
		end
	endtask

	// Word i of an unwritten line a is {a[31:5], i, 2'b00} ^ 32'h3c3c_a5a5
	function automatic cache_pkg::line_t expected_fill(input logic [31:0] addr);
		cache_pkg::line_t line;
		for (int i = 0; i < 8; i++) begin
			line[i*32 +: 32] = {addr[31:5], 3'(i), 2'b00} ^ 32'h3c3c_a5a5;
		end
		return line;
	endfunction

	function automatic logic [31:0] line_addr(input cache_pkg::tag_t tag,
		input cache_pkg::index_t idx);
		return {tag, idx, 5'b00000};
	endfunction

	// Tree pLRU victim with bit 2 picking the pair
	function automatic int plru_victim(input cache_pkg::plru_t s);
		if (!s[2]) begin
			return s[1] ? 1 : 0;
		end else begin
			return s[0] ? 3 : 2;
		end
	endfunction

	function automatic cache_pkg::plru_t plru_touch(input cache_pkg::plru_t s, input int way);
		cache_pkg::plru_t n;
		n = s;
		case (way)
			0: n = {1'b1, 1'b1, s[0]};
			1: n = {1'b1, 1'b0, s[0]};
			2: n = {1'b0, s[1], 1'b1};
			default: n = {1'b0, s[1], 1'b0};
		endcase
		return n;
	endfunction

	task automatic clear_model();
		for (int s = 0; s < `CACHE_SETS; s++) begin
			ref_plru[s] = '0;
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				ref_lines[s][w] = '0;
				ref_tags[s][w] = '0;
				ref_valid[s][w] = 1'b0;
				ref_dirty[s][w] = 1'b0;
			end
		end
	endtask

	// Update the reference and predict what the DUT should do
	task automatic predict_access(input logic [31:0] addr, input logic wr,
		input cache_pkg::line_t wdata, output cache_pkg::line_t exp_line,
		output logic exp_hit, output logic exp_wb, output logic [31:0] wb_addr,
		output cache_pkg::line_t wb_data);
		cache_pkg::index_t idx;
		cache_pkg::tag_t tag;
		logic [31:0] fill_addr;
		int way;
		idx = addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
		tag = addr[31:8];
		fill_addr = line_addr(tag, idx);
		way = -1;
		exp_wb = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (ref_valid[idx][w] && ref_tags[idx][w] == tag) begin
				way = w;
			end
		end
		exp_hit = (way >= 0);
		if (!exp_hit) begin
			way = plru_victim(ref_plru[idx]);
			if (ref_dirty[idx][way]) begin
				exp_wb = 1'b1;
				wb_addr = line_addr(ref_tags[idx][way], idx);
				wb_data = ref_lines[idx][way];
				ref_mem[wb_addr] = wb_data;
			end
			ref_lines[idx][way] = ref_mem.exists(fill_addr) ? ref_mem[fill_addr] :
				expected_fill(fill_addr);
			ref_tags[idx][way] = tag;
			ref_valid[idx][way] = 1'b1;
			ref_dirty[idx][way] = 1'b0;
		end
		ref_plru[idx] = plru_touch(ref_plru[idx], way);
		if (wr) begin
			ref_lines[idx][way] = wdata;
			ref_dirty[idx][way] = 1'b1;
		end
		exp_line = ref_lines[idx][way];
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (rst && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (rst) begin
			$display("Timeout: reset was never released");
			stop_with_failure();
		end
	endtask

	// Hold the request until mem_resp, then drop it after the next edge
	task automatic run_access(input logic [31:0] addr, input logic wr,
		input cache_pkg::line_t wdata, output cache_pkg::line_t rdata, output int cycles);
		int n;
		@(posedge clk);
		#2;
		mem_address = addr;
		mem_read = !wr;
		mem_write = wr;
		mem_wdata = wdata;
		@(negedge clk);
		n = 1;
		while (!mem_resp && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (!mem_resp) begin
			$display("Timeout: mem_resp did not arrive within 200 cycles of the request");
			stop_with_failure();
		end else begin
			rdata = mem_rdata;
			cycles = n;
			@(posedge clk);
			#2;
			mem_read = 1'b0;
			mem_write = 1'b0;
		end
	endtask

	task automatic check_access(input string name, input logic [31:0] addr, input logic wr,
		input cache_pkg::line_t wdata);
		cache_pkg::line_t exp_line;
		cache_pkg::line_t wb_data;
		cache_pkg::line_t got;
		logic [31:0] wb_addr;
		logic exp_hit;
		logic exp_wb;
		int reads0;
		int writes0;
		int cycles;
		reads0 = read_count;
		writes0 = write_count;
		predict_access(addr, wr, wdata, exp_line, exp_hit, exp_wb, wb_addr, wb_data);
		run_access(addr, wr, wdata, got, cycles);
		check_bit({name, " pmem request held"}, 1'b0, hold_error);
		check_count({name, " pmem reads"}, exp_hit ? 0 : 1, read_count - reads0);
		check_count({name, " pmem writes"}, exp_wb ? 1 : 0, write_count - writes0);
		if (!wr) begin
			check_line({name, " read data"}, exp_line, got);
		end
		if (exp_hit) begin
			check_count({name, " hit latency"}, 2, cycles);
		end else begin
			check_addr({name, " fill address"}, {addr[31:5], 5'b00000}, last_read_addr);
		end
		if (exp_wb) begin
			check_addr({name, " writeback address"}, wb_addr, last_write_addr);
			check_line({name, " writeback data"}, wb_data, last_write_data);
		end
	endtask

	task automatic reset_state_test();
		@(negedge clk);
		check_bit("reset mem_resp", 1'b0, mem_resp);
		check_bit("reset pmem_read", 1'b0, pmem_read);
		check_bit("reset pmem_write", 1'b0, pmem_write);
		check_access("reset first read", 32'h0001_2004, 1'b0, '0);
	endtask

	task automatic read_hit_test();
		check_access("read miss", 32'h0003_404c, 1'b0, '0);
		check_access("read hit", 32'h0003_404c, 1'b0, '0);
	endtask

	task automatic write_hit_test();
		check_access("write hit fill", 32'h0005_6020, 1'b0, '0);
		check_access("write hit", 32'h0005_6020, 1'b1, {4{64'h0123_4567_89ab_cdef}});
		check_access("write hit readback", 32'h0005_6020, 1'b0, '0);
	endtask

	task automatic replacement_test();
		for (int k = 0; k < 5; k++) begin
			check_access("replace fill", line_addr(24'h0a0000 + 24'(k), 3'd3), 1'b0, '0);
		end
		// Fifth fill lands in way 0 again and pushes out the first tag
		for (int k = 1; k < 5; k++) begin
			check_access("replace survivor", line_addr(24'h0a0000 + 24'(k), 3'd3), 1'b0, '0);
		end
		check_access("replace victim", line_addr(24'h0a0000, 3'd3), 1'b0, '0);
	endtask

	task automatic writeback_test();
		cache_pkg::line_t wd;
		logic [31:0] a;
		int writes0;
		wd = {8{32'h5eed_0005}};
		a = line_addr(24'h0b0000, 3'd5);
		check_access("dirty write", a, 1'b1, wd);
		writes0 = write_count;
		for (int k = 1; k < 5; k++) begin
			check_access("dirty evict", line_addr(24'h0b0000 + 24'(k), 3'd5), 1'b0, '0);
		end
		check_count("dirty writeback count", 1, write_count - writes0);
		check_addr("dirty writeback address", a, last_write_addr);
		check_line("dirty writeback data", wd, last_write_data);
		writes0 = write_count;
		check_access("clean evict", line_addr(24'h0b0005, 3'd5), 1'b0, '0);
		check_count("clean evict writes", 0, write_count - writes0);
		// Written line must come back from memory
		check_access("dirty reread", a, 1'b0, '0);
	endtask

	task automatic stall_test();
		cache_pkg::line_t got;
		cache_pkg::line_t exp_line;
		cache_pkg::line_t wb_data;
		logic [31:0] wb_addr;
		logic exp_hit;
		logic exp_wb;
		int cycles;
		stall = 1'b1;
		predict_access(32'h0c00_00c0, 1'b0, '0, exp_line, exp_hit, exp_wb, wb_addr, wb_data);
		run_access(32'h0c00_00c0, 1'b0, '0, got, cycles);
		check_line("stall read data", exp_line, got);
		// Idle, check, seven allocate cycles with the response in the last, check again
		check_count("stall latency", 10, cycles);
		check_bit("stall pmem request held", 1'b0, hold_error);
		stall = 1'b0;
	endtask

	initial begin
		mem_address = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_wdata = '0;
		stall = 1'b0;
		clear_model();
		wait_reset_release();
		reset_state_test();
		read_hit_test();
		write_hit_test();
		replacement_test();
		writeback_test();
		stall_test();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/pmem_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module pmem_model (
	input logic clk,
	input logic rst,
	input logic [31:0] pmem_address,
	input logic pmem_read,
	input logic pmem_write,
	input cache_pkg::line_t pmem_wdata,
	output cache_pkg::line_t pmem_rdata,
	output logic pmem_resp,
	input logic stall,
	output int read_count,
	output int write_count,
	output logic [31:0] last_read_addr,
	output logic [31:0] last_write_addr,
	output cache_pkg::line_t last_write_data,
	output logic hold_error
);

	// Sparse store of written-back lines
	cache_pkg::line_t mem [logic [31:0]];

	// Word i of an unwritten line a is {a[31:5], i, 2'b00} ^ 32'h3c3c_a5a5
	function automatic cache_pkg::line_t default_line(input logic [31:0] addr);
		cache_pkg::line_t line;
		for (int i = 0; i < 8; i++) begin
			line[i*32 +: 32] = {addr[31:5], 3'(i), 2'b00} ^ 32'h3c3c_a5a5;
		end
		return line;
	endfunction

	initial begin
		logic [31:0] req_addr;
		logic is_write;
		int latency;
		pmem_rdata = '0;
		pmem_resp = 1'b0;
		read_count = 0;
		write_count = 0;
		last_read_addr = '0;
		last_write_addr = '0;
		last_write_data = '0;
		hold_error = 1'b0;
		void'($urandom(32'h1c66_4ee5));
		forever begin
			@(negedge clk);
			if (!rst && (pmem_read || pmem_write)) begin
				req_addr = pmem_address;
				is_write = pmem_write;
				latency = stall ? 6 : ($urandom % 6) + 1;
				// Cache must keep the request steady while we stall
				repeat (latency) begin
					@(posedge clk);
					#2;
					if (pmem_write != is_write || pmem_read == is_write ||
						pmem_address != req_addr) begin
						hold_error = 1'b1;
					end
				end
				if (is_write) begin
					mem[req_addr] = pmem_wdata;
					write_count = write_count + 1;
					last_write_addr = req_addr;
					last_write_data = pmem_wdata;
				end else begin
					pmem_rdata = mem.exists(req_addr) ? mem[req_addr] : default_line(req_addr);
					read_count = read_count + 1;
					last_read_addr = req_addr;
				end
				pmem_resp = 1'b1;
				@(posedge clk);
				#2 pmem_resp = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire
